// File: logic/mips_pkg.sv
/*
  Shared encodings for the single-cycle MIPS subset core.
  Only add, sub, and, or, slt, addi, lw, sw, beq and j are defined.
  ALU operation codes follow the classic 3-bit ALU control values.
*/
package mips_pkg;

  // opcode field, bits 31:26
  parameter logic [5:0] op_rtype = 6'h00;
  parameter logic [5:0] op_j     = 6'h02;
  parameter logic [5:0] op_beq   = 6'h04;
  parameter logic [5:0] op_addi  = 6'h08;
  parameter logic [5:0] op_lw    = 6'h23;
  parameter logic [5:0] op_sw    = 6'h2b;

  // function field of R-type words, bits 5:0
  parameter logic [5:0] funct_add = 6'h20;
  parameter logic [5:0] funct_sub = 6'h22;
  parameter logic [5:0] funct_and = 6'h24;
  parameter logic [5:0] funct_or  = 6'h25;
  parameter logic [5:0] funct_slt = 6'h2a;

  typedef enum logic [2:0] {
    alu_and = 3'b000,
    alu_or  = 3'b001,
    alu_add = 3'b010,
    alu_sub = 3'b110,
    alu_slt = 3'b111
  } alu_op_t;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fields_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fields_t;

  // one instruction word, two readings; the j target is bits 25:0
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_t;

endpackage

// File: logic/mips_alu.sv
/*
  32-bit ALU for the subset core.
  slt compares as signed and yields 1 or 0.
  zero flags an all-zero result and drives the beq decision.
*/
`timescale 1ns/1ns

module mips_alu (
  input  logic [31:0]        a,
  input  logic [31:0]        b,
  input  mips_pkg::alu_op_t  alu_op,
  output logic [31:0]        result,
  output logic               zero
);

  logic [31:0] sum;
  logic [31:0] diff;

  assign sum  = a + b;
  assign diff = a - b;

  always_comb begin
    case (alu_op)
      mips_pkg::alu_add: result = sum;
      mips_pkg::alu_sub: result = diff;
      mips_pkg::alu_and: result = a & b;
      mips_pkg::alu_or:  result = a | b;
      mips_pkg::alu_slt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default:           result = sum;
    endcase
  end

  assign zero = (result == 32'd0);

  // beq needs subtract to report zero exactly when the operands match
  always_comb begin
    if (alu_op == mips_pkg::alu_sub) begin
      a_zero_match: assert (zero == (a == b));
    end
  end

endmodule

// File: logic/mips_control.sv
/*
  Main decoder and ALU decoder, purely combinational.
  Both write enables are held low while rst is high.
  Unknown opcodes and unknown R-type function codes cause no writes.
*/
`timescale 1ns/1ns

module mips_control (
  input  logic                clk,
  input  logic                rst,
  input  mips_pkg::instr_t    instr,
  output logic                reg_write,
  output logic                mem_write,
  output logic                mem_to_reg,
  output logic                alu_src,
  output logic                reg_dst,
  output logic                branch,
  output logic                jump,
  output mips_pkg::alu_op_t   alu_op
);

  logic reg_write_dec;
  logic mem_write_dec;
  logic funct_ok;

  // main decoder
  always_comb begin
    reg_write_dec = 1'b0;
    mem_write_dec = 1'b0;
    mem_to_reg    = 1'b0;
    alu_src       = 1'b0;
    reg_dst       = 1'b0;
    branch        = 1'b0;
    jump          = 1'b0;
    case (instr.r.opcode)
      mips_pkg::op_rtype: begin
        reg_write_dec = funct_ok;
        reg_dst       = 1'b1;
      end
      mips_pkg::op_lw: begin
        reg_write_dec = 1'b1;
        alu_src       = 1'b1;
        mem_to_reg    = 1'b1;
      end
      mips_pkg::op_sw: begin
        mem_write_dec = 1'b1;
        alu_src       = 1'b1;
      end
      mips_pkg::op_addi: begin
        reg_write_dec = 1'b1;
        alu_src       = 1'b1;
      end
      mips_pkg::op_beq: branch = 1'b1;
      mips_pkg::op_j:   jump   = 1'b1;
      default: ;
    endcase
  end

  // alu decoder, memory ops and addi add, beq compares by subtracting
  always_comb begin
    funct_ok = 1'b1;
    case (instr.r.opcode)
      mips_pkg::op_rtype: begin
        case (instr.r.funct)
          mips_pkg::funct_add: alu_op = mips_pkg::alu_add;
          mips_pkg::funct_sub: alu_op = mips_pkg::alu_sub;
          mips_pkg::funct_and: alu_op = mips_pkg::alu_and;
          mips_pkg::funct_or:  alu_op = mips_pkg::alu_or;
          mips_pkg::funct_slt: alu_op = mips_pkg::alu_slt;
          default: begin
            alu_op   = mips_pkg::alu_add;
            funct_ok = 1'b0;
          end
        endcase
      end
      mips_pkg::op_beq: alu_op = mips_pkg::alu_sub;
      default:          alu_op = mips_pkg::alu_add;
    endcase
  end

  assign reg_write = reg_write_dec & ~rst;
  assign mem_write = mem_write_dec & ~rst;

  // a store never writes back, across the whole decode
  a_no_dual_write: assert property (@(posedge clk) !(reg_write && mem_write));

endmodule

// File: logic/mips_regfile.sv
/*
  32 x 32 register file, two combinational reads, one write on the clock edge.
  Register 0 reads as zero and ignores writes.
  rst clears every register.
*/
`timescale 1ns/1ns

module mips_regfile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  ra1,
  input  logic [4:0]  ra2,
  input  logic [4:0]  wa,
  input  logic        we,
  input  logic [31:0] wd,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= 32'd0;
      end
    end else if (we && (wa != 5'd0)) begin
      regs[wa] <= wd;
    end
  end

  // no write-through, the write lands at the end of the cycle
  assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

  a_r0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == 32'd0);

endmodule

// File: logic/mips_pc_unit.sv
/*
  Program counter and next-address selection.
  Priority is jump, then taken branch, then pc + 4.
  reset_pc must be word aligned.
*/
`timescale 1ns/1ns

module mips_pc_unit #(
  parameter logic [31:0] reset_pc = 32'd0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        branch,
  input  logic        jump,
  input  logic        zero,
  input  logic [31:0] imm_ext,
  input  logic [25:0] jump_target,
  output logic [31:0] pc
);

  logic [31:0] pc_plus4;
  logic [31:0] pc_branch;
  logic [31:0] pc_jump;
  logic [31:0] pc_next;

  assign pc_plus4  = pc + 32'd4;
  assign pc_branch = pc_plus4 + {imm_ext[29:0], 2'b00};
  // pseudo-direct, stays in the current 256 MB region
  assign pc_jump   = {pc_plus4[31:28], jump_target, 2'b00};

  always_comb begin
    if (jump) begin
      pc_next = pc_jump;
    end else if (branch && zero) begin
      pc_next = pc_branch;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) pc <= reset_pc;
    else     pc <= pc_next;
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// File: logic/mips_cpu.sv
/*
  Single-cycle MIPS subset core, one instruction per clock.
  Instruction and data memories are external and read combinationally.
  The data memory write happens on the edge that ends the cycle.
  No byte or halfword access, no exceptions, no jal or jr.
*/
`timescale 1ns/1ns

module mips_cpu #(
  parameter logic [31:0] reset_pc = 32'd0
) (
  input  logic        clk,
  input  logic        rst,
  output logic [31:0] pc,
  input  logic [31:0] instr,
  output logic [31:0] dmem_addr,
  output logic [31:0] dmem_wdata,
  output logic        dmem_we,
  input  logic [31:0] dmem_rdata
);

  mips_pkg::instr_t  instr_u;
  mips_pkg::alu_op_t alu_op;

  logic        reg_write;
  logic        mem_write;
  logic        mem_to_reg;
  logic        alu_src;
  logic        reg_dst;
  logic        branch;
  logic        jump;
  logic        zero;
  logic [4:0]  write_reg;
  logic [31:0] imm_ext;
  logic [31:0] rd1;
  logic [31:0] rd2;
  logic [31:0] src_b;
  logic [31:0] alu_result;
  logic [31:0] write_back;

  assign instr_u = instr;

  mips_control i_mips_control (
    .clk        (clk),
    .rst        (rst),
    .instr      (instr_u),
    .reg_write  (reg_write),
    .mem_write  (mem_write),
    .mem_to_reg (mem_to_reg),
    .alu_src    (alu_src),
    .reg_dst    (reg_dst),
    .branch     (branch),
    .jump       (jump),
    .alu_op     (alu_op)
  );

  // rd for R-type, rt for addi and lw
  assign write_reg = reg_dst ? instr_u.r.rd : instr_u.r.rt;
  assign imm_ext   = {{16{instr_u.i.imm[15]}}, instr_u.i.imm};

  mips_regfile i_mips_regfile (
    .clk (clk),
    .rst (rst),
    .ra1 (instr_u.r.rs),
    .ra2 (instr_u.r.rt),
    .wa  (write_reg),
    .we  (reg_write),
    .wd  (write_back),
    .rd1 (rd1),
    .rd2 (rd2)
  );

  assign src_b = alu_src ? imm_ext : rd2;

  mips_alu i_mips_alu (
    .a      (rd1),
    .b      (src_b),
    .alu_op (alu_op),
    .result (alu_result),
    .zero   (zero)
  );

  mips_pc_unit #(
    .reset_pc (reset_pc)
  ) i_mips_pc_unit (
    .clk         (clk),
    .rst         (rst),
    .branch      (branch),
    .jump        (jump),
    .zero        (zero),
    .imm_ext     (imm_ext),
    .jump_target (instr_u[25:0]),
    .pc          (pc)
  );

  // memory side
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rd2;
  assign dmem_we    = mem_write;

  // lw writes back in the same cycle since the memory read is combinational
  assign write_back = mem_to_reg ? dmem_rdata : alu_result;

endmodule

// File: sim/tb_mips_cpu.sv
/*
  Testbench for mips_cpu, run from the project root.
  Program words and expected stores come from sim/mips_patterns.hex.
  Each test closes with a marker store to 0x200 whose data is the test number.
  Data memory covers the low 1 KB only.
*/
`timescale 1ns/1ns

module tb_mips_cpu;

  localparam int          clk_period   = 8;
  localparam int          reset_cycles = 5;
  localparam logic [31:0] marker_addr  = 32'h0000_0200;

  logic        clk;
  logic        rst;
  logic [31:0] pc;
  logic [31:0] instr;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_we;
  logic [31:0] dmem_rdata;

  // word 0 instruction count, word 1 store count, program, then store pairs
  logic [31:0] pat [256];
  logic [31:0] dmem [256];

  int          instr_count;
  int          store_count;
  int          store_base;
  int          store_idx;
  int          test_num;
  int          test_errors;
  int          pass_count;
  int          fail_count;
  int          extra_stores;
  logic [31:0] last_pc;

  mips_cpu #(
    .reset_pc (32'd0)
  ) i_mips_cpu (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .instr      (instr),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // instruction memory, fetches past the program read as a no-op word
  always_comb begin
    if (int'(pc[31:2]) < instr_count) begin
      instr = pat[2 + int'(pc[31:2])];
    end else begin
      instr = 32'd0;
    end
  end

  always_comb begin
    if (dmem_addr < 32'h400) begin
      dmem_rdata = dmem[dmem_addr[9:2]];
    end else begin
      dmem_rdata = 32'd0;
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < 256; k++) begin
        dmem[k] <= 32'd0;
      end
    end else if (dmem_we && (dmem_addr < 32'h400)) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  function automatic string test_name(input int n);
    case (n)
      1:       return "alu_ops";
      2:       return "addi_sign_extend";
      3:       return "store_then_load";
      4:       return "beq_taken_and_not_taken";
      5:       return "jump_over_store";
      6:       return "reg0_write_discarded";
      default: return "unnamed";
    endcase
  endfunction

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      pass_count++;
      $display("test %0d %s passed", test_num, name);
    end else begin
      fail_count++;
      $display("test %0d %s failed with %0d mismatches", test_num, name, test_errors);
    end
    test_errors = 0;
    test_num++;
  endtask

  task automatic check_store();
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    string       name;
    if (store_idx >= store_count) begin
      extra_stores++;
      $display("unexpected store of %h to address %h after all expected stores",
               dmem_wdata, dmem_addr);
    end else begin
      exp_addr = pat[store_base + 2 * store_idx];
      exp_data = pat[store_base + 2 * store_idx + 1];
      name     = test_name(test_num);
      if (dmem_addr !== exp_addr) begin
        test_errors++;
        $display("[FAIL] %s store %0d address expected %h actual %h",
                 name, store_idx, exp_addr, dmem_addr);
      end
      if (dmem_wdata !== exp_data) begin
        test_errors++;
        $display("[FAIL] %s store %0d data expected %h actual %h",
                 name, store_idx, exp_data, dmem_wdata);
      end
      store_idx++;
      // marker store closes the running test
      if (exp_addr == marker_addr) begin
        finish_test(name);
      end
    end
  endtask

  task automatic print_counts();
    $display("tests passed %0d, tests failed %0d, unexpected stores %0d, stores seen %0d of %0d",
             pass_count, fail_count, extra_stores, store_idx, store_count);
  endtask

  // stores are checked mid-cycle where the datapath has settled
  always @(negedge clk) begin
    if (!rst && dmem_we) begin
      check_store();
    end
  end

  initial begin
    rst          = 1'b1;
    store_idx    = 0;
    test_num     = 1;
    test_errors  = 0;
    pass_count   = 0;
    fail_count   = 0;
    extra_stores = 0;
    for (int k = 0; k < 256; k++) begin
      pat[k] = 32'd0;
    end
    $readmemh("sim/mips_patterns.hex", pat);
    instr_count = int'(pat[0]);
    store_count = int'(pat[1]);
    store_base  = 2 + instr_count;
    last_pc     = 32'(instr_count - 1) * 32'd4;

    repeat (reset_cycles) @(posedge clk);
    #1 rst = 1'b0;

    // the program parks on a self-jump as its last word
    while (pc != last_pc) begin
      @(negedge clk);
    end
    // stay a few cycles on the self-jump for stray stores
    repeat (4) @(posedge clk);

    if (store_idx < store_count) begin
      $display("program reached its final jump with %0d expected stores never seen",
               store_count - store_idx);
    end
    print_counts();
    if (fail_count == 0 && extra_stores == 0 && store_idx == store_count && pass_count > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    @(negedge rst);
    limit = instr_count * 4 + 50;
    repeat (limit) @(posedge clk);
    $display("watchdog timeout after %0d cycles, %0d expected stores still missing",
             limit, store_count - store_idx);
    print_counts();
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: sim/mips_patterns.hex
// first two words are the instruction count and the expected store count
// then the program words, then expected stores as address and data pairs
00000031 00000015
// test 1 alu ops with r1 = 7 and r2 = -3
20010007 2002FFFD 00221820 AC030000
00222022 AC040004 00222824 AC050008
00223025 AC06000C 0041382A AC070010
0022402A AC080014 20090001 AC090200
// test 2 addi with negative immediates
202AFF9C AC0A0020 200B8000 AC0B0024
20090002 AC090200
// test 3 store then load back, direct and through a base register
200C1234 AC0C0040 8C0D0040 AC0D0044
200E0060 ADC60004 8DCF0004 ADCF0008
20090003 AC090200
// test 4 beq taken skips the store to 0x80, not taken runs the store to 0x84
10210001 AC010080 10220001 AC020084
20090004 AC090200
// test 5 j to word 40 skips the store to 0xa0
08000028 AC0100A0 AC0300A4 20090005
AC090200
// test 6 writes to r0 then stores r0, last word is the self-jump
20000037 00210020 AC0000C0 20090006
AC090200 08000030
// expected stores in program order
00000000 00000004 00000004 0000000A
00000008 00000005 0000000C FFFFFFFF
00000010 00000001 00000014 00000000
00000200 00000001
00000020 FFFFFFA3 00000024 FFFF8000
00000200 00000002
00000040 00001234 00000044 00001234
00000064 FFFFFFFF 00000068 FFFFFFFF
00000200 00000003
00000084 FFFFFFFD 00000200 00000004
000000A4 00000004 00000200 00000005
000000C0 00000000 00000200 00000006

// File: project.f
logic/mips_pkg.sv
logic/mips_alu.sv
logic/mips_control.sv
logic/mips_regfile.sv
logic/mips_pc_unit.sv
logic/mips_cpu.sv
sim/tb_mips_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the mips_cpu testbench with Verilator from the project root
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f project.f \
  --top-module tb_mips_cpu \
  -o sim_tb_mips_cpu

./obj_dir/sim_tb_mips_cpu | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
